// ==== wbe_mem_top.f ====
mem_cfg_pkg.sv
mem_types_pkg.sv
mem_req_if.sv
req_credit_fifo.sv
wbe_sram.sv
mem_issue_ctrl.sv
wbe_mem_top.sv
tb_wbe_mem_assert.sv
tb_wbe_mem_top.sv

// ==== Bender.yml ====
package:
  name: wbe_mem

sources:
  # Packages first, then the interface and the RTL in dependency order
  - mem_cfg_pkg.sv
  - mem_types_pkg.sv
  - mem_req_if.sv
  - req_credit_fifo.sv
  - wbe_sram.sv
  - mem_issue_ctrl.sv
  - wbe_mem_top.sv
  - target: test
    files:
      - tb_wbe_mem_assert.sv
      - tb_wbe_mem_top.sv

// ==== tb_wbe_mem_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the credit-controlled byte-writable memory.
// Seeded LFSR requests are checked in order against a shadow
// memory, and credit flow on both sides is counted.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_wbe_mem_top;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DEPTH      = 2 ** ADDR_W;
    localparam int RW_PAIRS   = 4;
    localparam int PARTIAL_N  = 24;
    localparam int SOAK_N     = 300;
    localparam int N_REQ      = DEPTH + 2 * RW_PAIRS + PARTIAL_N + REQ_DEPTH + SOAK_N;
    localparam logic [15:0] SEED = 16'd67;

    logic      clk;
    logic      rst;
    logic      req_valid;
    mem_addr_t req_addr;
    mem_be_t   req_be;
    mem_word_t req_wdata;
    logic      rsp_credit;
    logic      req_credit;
    logic      rsp_valid;
    mem_word_t rsp_rdata;

    int          sent_cnt      = 0;   // Requests driven by the sender
    int          credit_pulses = 0;
    int          rsp_cnt       = 0;
    int          rel_cnt       = 0;   // Slots freed by the consumer
    int          held          = 0;
    int          delay         = 0;
    int          value_errs    = 0;
    int          other_errs    = 0;
    logic        withhold;            // Consumer keeps its slots
    logic [15:0] stim_lfsr;
    logic [15:0] cons_lfsr;
    mem_word_t   shadow [DEPTH];
    mem_word_t   exp_q [$];           // Expected read data in order
    bit          chk_q [$];

    wbe_mem_top #(
        .ADDR_W      (ADDR_W),
        .DATA_W      (DATA_W),
        .REQ_DEPTH   (REQ_DEPTH),
        .RSP_CREDITS (RSP_CREDITS)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_be     (req_be),
        .req_wdata  (req_wdata),
        .rsp_credit (rsp_credit),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);   // Galois taps 16,14,13,11
    endfunction

    task automatic draw_bits(inout logic [15:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = st[0];
            st   = lfsr_next(st);
        end
    endtask

    task automatic check_word(input mem_word_t got, input mem_word_t exp, input string name);
        if (got !== exp) begin
            value_errs++;
            $display("Fail %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string name);
        if (got != exp) begin
            value_errs++;
            $display("Fail %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Waits for a sender credit, then drives one request and updates the model
    task automatic send_req(input mem_addr_t a, input mem_be_t be, input mem_word_t d,
                            input bit chk);
        mem_word_t old;
        while (REQ_DEPTH - sent_cnt + credit_pulses <= 0) begin
            req_valid <= 1'b0;
            @(posedge clk);
        end
        old = shadow[a];
        for (int i = 0; i < LANES; i++) begin
            if (be[i]) begin
                shadow[a][i*8 +: 8] = d[i*8 +: 8];
            end
        end
        exp_q.push_back(old);         // Read-before-write
        chk_q.push_back(chk);
        req_valid <= 1'b1;
        req_addr  <= a;
        req_be    <= be;
        req_wdata <= d;
        sent_cnt++;
        @(posedge clk);
    endtask

    task automatic idle_cycle();
        req_valid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_drain();
        req_valid <= 1'b0;
        while (rsp_cnt < sent_cnt || rel_cnt < sent_cnt) begin
            @(posedge clk);
        end
    endtask

    // Response monitor and consumer
    always @(posedge clk) begin
        logic [31:0] r;
        if (rst) begin
            rsp_credit <= 1'b0;
            held = 0;
            delay = 0;
        end else begin
            if (req_credit) begin
                credit_pulses <= credit_pulses + 1;
            end
            if (rsp_valid) begin
                rsp_cnt <= rsp_cnt + 1;
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("Response at %0t ns with no request outstanding", $time);
                end else if (chk_q.pop_front()) begin
                    check_word(rsp_rdata, exp_q.pop_front(), "rsp_rdata");
                end else begin
                    void'(exp_q.pop_front());   // Memory still unknown
                end
                held++;
                if (held > RSP_CREDITS) begin
                    other_errs++;
                    $display("Response at %0t ns arrived with no free slot", $time);
                end
            end
            if (held > 0 && !withhold && delay == 0) begin
                rsp_credit <= 1'b1;
                rel_cnt    <= rel_cnt + 1;
                held--;
                draw_bits(cons_lfsr, 2, r);
                delay = r;
            end else begin
                rsp_credit <= 1'b0;
                if (delay > 0) begin
                    delay--;
                end
            end
        end
    end

    initial begin
        logic [31:0] r_addr;
        logic [31:0] r_be;
        logic [31:0] r_data;
        logic [31:0] r_op;
        int          noisy;
        int          base;
        int          assert_errs;
        clk        = 1'b0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_be     = '0;
        req_wdata  = '0;
        rsp_credit = 1'b0;
        withhold   = 1'b0;
        stim_lfsr  = SEED;
        cons_lfsr  = SEED;
        noisy      = 0;

        // Reset for three cycles, outputs quiet through and after it
        @(posedge clk);
        for (int c = 2; c <= 5; c++) begin
            @(posedge clk);
            if (rsp_valid !== 1'b0 || req_credit !== 1'b0) begin
                noisy++;
            end
            if (c == 3) begin
                rst <= 1'b0;
            end
        end
        check_count(noisy, 0, "pulses around reset");

        for (int a = 0; a < DEPTH; a++) begin
            send_req(mem_addr_t'(a), '1, '0, 1'b0);   // Clear memory, old data unknown
        end

        for (int n = 0; n < RW_PAIRS; n++) begin
            draw_bits(stim_lfsr, ADDR_W, r_addr);
            draw_bits(stim_lfsr, DATA_W, r_data);
            send_req(mem_addr_t'(r_addr), '1, mem_word_t'(r_data), 1'b1);
            draw_bits(stim_lfsr, DATA_W, r_data);
            send_req(mem_addr_t'(r_addr), '0, mem_word_t'(r_data), 1'b1);
        end

        // Partial writes on a few addresses so lanes overlap
        for (int n = 0; n < PARTIAL_N; n++) begin
            draw_bits(stim_lfsr, 3, r_addr);
            draw_bits(stim_lfsr, LANES, r_be);
            draw_bits(stim_lfsr, DATA_W, r_data);
            send_req(mem_addr_t'(r_addr), mem_be_t'(r_be), mem_word_t'(r_data), 1'b1);
        end
        wait_drain();

        // Back-pressure with a full burst of sender credits
        withhold <= 1'b1;
        base = rsp_cnt;
        for (int n = 0; n < REQ_DEPTH; n++) begin
            draw_bits(stim_lfsr, ADDR_W, r_addr);
            draw_bits(stim_lfsr, DATA_W, r_data);
            send_req(mem_addr_t'(r_addr), '1, mem_word_t'(r_data), 1'b1);
        end
        req_valid <= 1'b0;
        repeat (10) @(posedge clk);
        check_count(rsp_cnt - base, RSP_CREDITS, "responses while credit withheld");
        withhold <= 1'b0;
        wait_drain();
        check_count(rsp_cnt - base, REQ_DEPTH, "responses after credit returned");

        for (int n = 0; n < SOAK_N; n++) begin
            draw_bits(stim_lfsr, 1, r_op);
            draw_bits(stim_lfsr, ADDR_W, r_addr);
            draw_bits(stim_lfsr, LANES, r_be);
            draw_bits(stim_lfsr, DATA_W, r_data);
            send_req(mem_addr_t'(r_addr), r_op[0] ? mem_be_t'(r_be) : '0,
                     mem_word_t'(r_data), 1'b1);
            draw_bits(stim_lfsr, 2, r_op);
            if (r_op[1:0] == 2'b00) begin
                idle_cycle();
            end
        end
        wait_drain();

        check_count(rsp_cnt, sent_cnt, "response count");
        check_count(credit_pulses, sent_cnt, "req_credit pulses");
        check_count(REQ_DEPTH - sent_cnt + credit_pulses, REQ_DEPTH, "sender credits");
        check_count(exp_q.size(), 0, "responses outstanding");

        assert_errs = dut0.u_ctrl.u_assert.fail_cnt;
        $display("Errors: %0d value mismatches, %0d protocol errors, %0d assertion failures",
                 value_errs, other_errs, assert_errs);
        if (value_errs + other_errs + assert_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the request count plus reset
    initial begin
        #((N_REQ * 20 + 3) * CLK_PERIOD);
        $display("Timeout at %0t ns: requests still outstanding or sender stalled", $time);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_wbe_mem_assert.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the issue controller, bound into every
// instance of it. Covers the credit limit, the pop rule and the
// one-cycle response latency.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module issue_ctrl_assert #(
    parameter int RSP_CREDITS = mem_cfg_pkg::RSP_CREDITS
) (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 avail,
    input logic                                 take,
    input logic                                 rsp_credit,
    input logic [$clog2(RSP_CREDITS + 1)-1:0]   credit_cnt,
    input logic                                 rsp_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;   // Failures seen so far
    int exp_cnt;        // Free slots rebuilt from pops and returned credits

    always @(posedge clk) begin
        if (rst) begin
            exp_cnt <= RSP_CREDITS;
        end else begin
            exp_cnt <= exp_cnt - int'(take) + int'(rsp_credit);
        end
    end

    a_credit_limit: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= RSP_CREDITS)
        else begin fail_cnt++; $error("Response credit count above its limit"); end

    a_take_rule: assert property (@(posedge clk) disable iff (rst)
        take |-> (avail && exp_cnt > 0))
        else begin fail_cnt++; $error("Head popped while empty or without credit"); end

    // Response one cycle after each access the credits allow, and never otherwise
    a_rsp_latency: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (rsp_valid == $past(avail && exp_cnt > 0)))
        else begin fail_cnt++; $error("rsp_valid does not follow take by one cycle"); end

endmodule

bind mem_issue_ctrl issue_ctrl_assert #(
    .RSP_CREDITS (RSP_CREDITS)
) u_assert (
    .clk        (clk),
    .rst        (rst),
    .avail      (q.avail),
    .take       (q.take),
    .rsp_credit (rsp_credit),
    .credit_cnt (credit_cnt),
    .rsp_valid  (rsp_valid)
);

`default_nettype wire

// ==== wbe_mem_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Top level of the credit-controlled byte-writable memory.
// Requests enter on plain ports into the queue; one response
// per request leaves with the word read before its write.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module wbe_mem_top #(
    parameter int ADDR_W      = mem_cfg_pkg::ADDR_W,
    parameter int DATA_W      = mem_cfg_pkg::DATA_W,
    parameter int REQ_DEPTH   = mem_cfg_pkg::REQ_DEPTH,
    parameter int RSP_CREDITS = mem_cfg_pkg::RSP_CREDITS
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  mem_types_pkg::mem_addr_t req_addr,
    input  mem_types_pkg::mem_be_t   req_be,
    input  mem_types_pkg::mem_word_t req_wdata,
    input  logic                     rsp_credit,
    output logic                     req_credit,
    output logic                     rsp_valid,
    output mem_types_pkg::mem_word_t rsp_rdata
);
    import mem_types_pkg::*;

    mem_req_t  push_req;
    logic      ram_en;
    mem_addr_t ram_addr;
    mem_be_t   ram_be;
    mem_word_t ram_wdata;
    mem_word_t ram_rdata;

    mem_req_if req_q ();

    assign push_req = '{addr: req_addr, be: req_be, wdata: req_wdata};

    req_credit_fifo #(
        .REQ_DEPTH (REQ_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (req_valid),      // Sender only asserts while holding credit
        .push_req (push_req),
        .credit   (req_credit),
        .q        (req_q.source)
    );

    mem_issue_ctrl #(
        .RSP_CREDITS (RSP_CREDITS)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .q          (req_q.sink),
        .rsp_credit (rsp_credit),
        .ram_rdata  (ram_rdata),
        .ram_en     (ram_en),
        .ram_addr   (ram_addr),
        .ram_be     (ram_be),
        .ram_wdata  (ram_wdata),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata)
    );

    wbe_sram #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) u_sram (
        .clk   (clk),
        .rst   (rst),
        .en    (ram_en),
        .addr  (ram_addr),
        .be    (ram_be),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== mem_issue_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Issue controller. Counts response slots free at the consumer
// and releases the queue head to the RAM only while one is free.
// The response follows the access by the fixed RAM latency.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mem_issue_ctrl #(
    parameter int RSP_CREDITS = mem_cfg_pkg::RSP_CREDITS
) (
    input  logic                     clk,
    input  logic                     rst,
    mem_req_if.sink                  q,
    input  logic                     rsp_credit,
    input  mem_types_pkg::mem_word_t ram_rdata,
    output logic                     ram_en,
    output mem_types_pkg::mem_addr_t ram_addr,
    output mem_types_pkg::mem_be_t   ram_be,
    output mem_types_pkg::mem_word_t ram_wdata,
    output logic                     rsp_valid,
    output mem_types_pkg::mem_word_t rsp_rdata
);
    import mem_types_pkg::*;

    localparam int CNT_W = $clog2(RSP_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;   // Free response slots at the consumer
    logic             issue;
    mem_req_t         head;

    assign head   = q.req;
    assign issue  = q.avail && (credit_cnt != '0);
    assign q.take = issue;          // Pop in the same cycle as the access

    // RAM request straight from the queue head
    assign ram_en    = issue;
    assign ram_addr  = head.addr;
    assign ram_be    = head.be;
    assign ram_wdata = head.wdata;

    // Read register is already aligned with rsp_valid
    assign rsp_rdata = ram_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CNT_W'(RSP_CREDITS);
            rsp_valid  <= 1'b0;
        end else begin
            case ({issue, rsp_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;   // Slot spent
                2'b01:   credit_cnt <= credit_cnt + 1'b1;   // Slot freed
                default: credit_cnt <= credit_cnt;
            endcase
            rsp_valid <= issue;     // RAM read latency of one
        end
    end

endmodule

`default_nettype wire

// ==== wbe_sram.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Single-port RAM with per-byte write enable and a registered
// read port. The read register returns the word as it was
// before the write at the same edge, and is cleared by reset.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module wbe_sram #(
    parameter int ADDR_W = mem_cfg_pkg::ADDR_W,
    parameter int DATA_W = mem_cfg_pkg::DATA_W
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     en,
    input  mem_types_pkg::mem_addr_t addr,
    input  mem_types_pkg::mem_be_t   be,
    input  mem_types_pkg::mem_word_t wdata,
    output mem_types_pkg::mem_word_t rdata
);
    import mem_types_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;
    localparam int LANES = DATA_W / 8;

    mem_word_t mem [DEPTH];   // Contents survive reset

    // Byte-lane writes; be of zero leaves the word untouched
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < LANES; i++) begin
                if (be[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // Read-before-write output register
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (en) begin
            rdata <= mem[addr];     // Old word, write lands after this edge
        end
    end

endmodule

`default_nettype wire

// ==== req_credit_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Request queue in front of the memory. The sender pushes only
// while it holds credit; each entry popped by the controller
// returns one credit a cycle later.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module req_credit_fifo #(
    parameter int REQ_DEPTH = mem_cfg_pkg::REQ_DEPTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  mem_types_pkg::mem_req_t push_req,
    output logic                    credit,
    mem_req_if.source               q
);
    import mem_types_pkg::*;

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);

    mem_req_t         entries [REQ_DEPTH];   // Payload storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                 // Occupancy
    logic             pop;

    // Pointer advance with wrap for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        logic [PTR_W-1:0] n;
        if (p == PTR_W'(REQ_DEPTH - 1)) begin
            n = '0;
        end else begin
            n = p + 1'b1;
        end
        return n;
    endfunction

    assign pop     = q.take;
    assign q.avail = (count != '0);
    assign q.req   = entries[rd_ptr];      // Head shown combinationally

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle or push and pop together
            endcase
            credit <= pop;                   // One credit back per released entry
        end
    end

endmodule

`default_nettype wire

// ==== mem_req_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Head-of-queue handshake between the request queue and the
// issue controller. The queue shows the head entry, the
// controller pops it with take in the same cycle.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface mem_req_if;
    import mem_types_pkg::*;

    logic     avail;   // Queue not empty
    mem_req_t req;     // Entry at the head
    logic     take;    // Pop the head, only while avail

    modport source (
        output avail,
        output req,
        input  take
    );

    modport sink (
        input  avail,
        input  req,
        output take
    );

endinterface

`default_nettype wire

// ==== mem_types_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Data types shared by the memory RTL and its testbench.
// Sized from the defaults in the sizing constants package.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mem_types_pkg;

    typedef logic [mem_cfg_pkg::DATA_W-1:0] mem_word_t;   // One data word
    typedef logic [mem_cfg_pkg::LANES-1:0]  mem_be_t;     // Bit i writes byte i
    typedef logic [mem_cfg_pkg::ADDR_W-1:0] mem_addr_t;   // Word address

    // One queued request
    // A byte-enable of all zeros makes it a pure read
    typedef struct packed {
        mem_addr_t addr;
        mem_be_t   be;
        mem_word_t wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== mem_cfg_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Sizing constants for the byte-writable memory subsystem.
// Used as defaults for the top-level parameters and to size
// the shared types.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mem_cfg_pkg;

    // Memory geometry
    localparam int ADDR_W = 6;            // 64 words
    localparam int DATA_W = 32;           // Word width in bits
    localparam int LANES  = DATA_W / 8;   // Byte lanes per word

    // Flow control
    localparam int REQ_DEPTH   = 4;       // Queue entries, also sender's start credit
    localparam int RSP_CREDITS = 2;       // Response slots held by the consumer

endpackage

`default_nettype wire
